// ==== project.f ====
design/probePkg.sv
design/cmdDecoder.sv
design/probeValue.sv
design/upLinkArbiter.sv
design/probeHub.sv
verif/probeHubTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the probe hub testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module probeHubTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VprobeHubTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
   echo "Simulation reported a failure, see $LOG"
   exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== verif/probeHubTb.sv ====
module probeHubTb;

   localparam int maxCycles = 4000;  // Tests need roughly 600 cycles

   logic                             CLK;
   logic                             rstN;
   logic                             cmdEn;
   logic [18:0]                      cmd;
   logic                             badCmd;
   logic [31:0]                      upData;
   logic                             upValid;
   logic                             ack;
   logic                             hostDelay;
   logic [probePkg::probeWidthA-1:0] probeInA;
   logic                             probeEnA;
   logic [probePkg::probeWidthB-1:0] probeInB;
   logic                             probeEnB;
   logic [probePkg::probeWidthC-1:0] probeInC;
   logic                             probeEnC;

   int     errors;
   int     cycleCount;
   integer seed;

   probeHub u_probeHub (
      .CLK       (CLK),
      .rstN      (rstN),
      .cmdEn     (cmdEn),
      .cmd       (cmd),
      .badCmd    (badCmd),
      .upData    (upData),
      .upValid   (upValid),
      .ack       (ack),
      .hostDelay (hostDelay),
      .probeInA  (probeInA),
      .probeEnA  (probeEnA),
      .probeInB  (probeInB),
      .probeEnB  (probeEnB),
      .probeInC  (probeInC),
      .probeEnC  (probeEnC)
   );

   initial begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   initial begin
      cycleCount = 0;
      while (cycleCount < maxCycles) begin
         @(posedge CLK);
         cycleCount++;
      end
      $display("Timeout after %0d cycles, the uplink never delivered an expected frame",
               maxCycles);
      $display("Result: FAILED");
      $finish;
   end

   // Returns badCmd as seen in the strobe cycle
   task automatic sendCmd(input logic [15:0] probeId, input logic [2:0] op,
                          output logic sawBad);
      cmd   = {probeId, op};
      cmdEn = 1'b1;
      @(negedge CLK);
      cmdEn  = 1'b0;
      sawBad = badCmd;
      @(negedge CLK);  // Probe state updates on this edge
   endtask

   // Caller passes the value zero padded
   task automatic collectFrame(input string testName, input logic [15:0] probeId,
                               input int words, input logic [63:0] value, input logic expDelay);
      probePkg::upWordT expWord;
      logic [31:0]      held;
      int               gap;
      while (!upValid) @(negedge CLK);
      for (int i = 0; i <= words; i++) begin
         if (i == 0) begin
            expWord.header.probeId   = probeId;
            expWord.header.reserved  = 8'd0;
            expWord.header.wordCount = 8'(words);
         end else begin
            expWord.data = value[32*(i-1) +: 32];  // Least significant word first
         end
         gap  = $unsigned($random(seed)) % 4;
         held = upData;
         repeat (gap) begin
            @(negedge CLK);
            if (!upValid || upData !== held) begin
               errors++;
               $display("%s: word %0d did not hold while ack was low", testName, i);
            end
         end
         if (!upValid) begin
            errors++;
            $display("%s: upValid dropped inside the frame at word %0d", testName, i);
         end
         if (upData !== expWord.data) begin
            errors++;
            $display("FAIL %s word %0d expected %h actual %h",
                     testName, i, expWord.data, upData);
         end
         if (hostDelay !== expDelay) begin
            errors++;
            $display("FAIL %s hostDelay expected %b actual %b", testName, expDelay, hostDelay);
         end
         ack = 1'b1;
         @(negedge CLK);
         ack = 1'b0;
      end
      if (upValid) begin
         errors++;
         $display("%s: upValid still high after the last word of the frame", testName);
      end
   endtask

   task automatic checkNoFrame(input string testName, input int cycles);
      repeat (cycles) begin
         @(negedge CLK);
         if (upValid || hostDelay) begin
            errors++;
            $display("FAIL %s upValid,hostDelay expected 0,0 actual %b,%b",
                     testName, upValid, hostDelay);
         end
      end
   endtask

   task automatic resetIdleTest();
      if (upValid || hostDelay || badCmd) begin
         errors++;
         $display("FAIL reset upValid,hostDelay,badCmd expected 0,0,0 actual %b,%b,%b",
                  upValid, hostDelay, badCmd);
      end
      probeInA = 8'h3c;
      probeInB = 40'h11_2233_4455;
      probeInC = 16'hbeef;
      checkNoFrame("reset", 20);
   endtask

   task automatic enableTest();
      logic bad;
      sendCmd(probePkg::probeIdA, probePkg::opEnable, bad);
      collectFrame("enableForced", probePkg::probeIdA, probePkg::probeWordsA,
                   64'(probeInA), 1'b0);
      probeInA = 8'h81;
      collectFrame("enableChange", probePkg::probeIdA, probePkg::probeWordsA, 64'h81, 1'b1);
      if (hostDelay) begin
         errors++;
         $display("FAIL enableChange hostDelay expected 0 actual %b", hostDelay);
      end
   endtask

   task automatic wideTest();
      logic bad;
      sendCmd(probePkg::probeIdB, probePkg::opEnable, bad);
      collectFrame("wideForced", probePkg::probeIdB, probePkg::probeWordsB,
                   64'(probeInB), 1'b0);
      probeInB = 40'ha5_1234_5678;
      collectFrame("wideChange", probePkg::probeIdB, probePkg::probeWordsB,
                   64'h0000_00a5_1234_5678, 1'b1);
   endtask

   task automatic sendOnceTest();
      logic bad;
      sendCmd(probePkg::probeIdC, probePkg::opSendOnce, bad);
      collectFrame("sendOnce", probePkg::probeIdC, probePkg::probeWordsC,
                   64'(probeInC), 1'b0);
      probeInC = 16'h1234;
      checkNoFrame("sendOnceQuiet", 30);
      probeInC = 16'h4321;
      checkNoFrame("sendOnceQuiet", 30);
   endtask

   task automatic contentionTest();
      logic        bad;
      logic [2:0]  seen;
      logic [15:0] id;
      logic [31:0] held;
      sendCmd(probePkg::probeIdC, probePkg::opEnable, bad);
      collectFrame("contentionForced", probePkg::probeIdC, probePkg::probeWordsC,
                   64'(probeInC), 1'b0);
      seen     = 3'b000;
      probeInA = 8'h5a;
      probeInB = 40'h01_cafe_f00d;
      probeInC = 16'h7e57;
      while (!upValid) @(negedge CLK);
      held = upData;
      repeat (10) begin  // Host stalls on the first header
         @(negedge CLK);
         if (!upValid || upData !== held) begin
            errors++;
            $display("contention: uplink word moved while ack was held low");
         end
      end
      repeat (3) begin
         while (!upValid) @(negedge CLK);
         id = upData[31:16];
         if (id == probePkg::probeIdA && !seen[0]) begin
            seen[0] = 1'b1;
            collectFrame("contentionA", probePkg::probeIdA, probePkg::probeWordsA,
                         64'h5a, 1'b1);
         end else if (id == probePkg::probeIdB && !seen[1]) begin
            seen[1] = 1'b1;
            collectFrame("contentionB", probePkg::probeIdB, probePkg::probeWordsB,
                         64'h01_cafe_f00d, 1'b1);
         end else if (id == probePkg::probeIdC && !seen[2]) begin
            seen[2] = 1'b1;
            collectFrame("contentionC", probePkg::probeIdC, probePkg::probeWordsC,
                         64'h7e57, 1'b1);
         end else begin
            errors++;
            $display("contention: header names probe %0d which was not due", id);
         end
      end
      if (seen != 3'b111) begin
         errors++;
         $display("contention: not every probe shipped its frame");
      end
      if (hostDelay) begin
         errors++;
         $display("FAIL contention hostDelay expected 0 actual %b", hostDelay);
      end
   endtask

   task automatic disableBadTest();
      logic bad;
      sendCmd(probePkg::probeIdA, 3'd0, bad);
      if (bad) begin
         errors++;
         $display("FAIL disable badCmd expected 0 actual %b", bad);
      end
      probeInA = 8'h99;
      checkNoFrame("disable", 20);
      sendCmd(16'd9, probePkg::opEnable, bad);
      if (bad !== 1'b1) begin
         errors++;
         $display("FAIL badCmd pulse expected %b actual %b", 1'b1, bad);
      end
      if (badCmd) begin
         errors++;
         $display("FAIL badCmd pulse end expected 0 actual %b", badCmd);
      end
      checkNoFrame("badCmd", 20);
      probeInA = 8'h42;  // Still disabled
      probeInB = 40'h77_0000_0001;
      collectFrame("badCmdB", probePkg::probeIdB, probePkg::probeWordsB,
                   64'h77_0000_0001, 1'b1);
      checkNoFrame("badCmdAfter", 20);
   endtask

   initial begin
      errors   = 0;
      seed     = 32'h3de448b9;
      rstN     = 1'b0;
      cmdEn    = 1'b0;
      cmd      = '0;
      ack      = 1'b0;
      probeInA = '0;
      probeInB = '0;
      probeInC = '0;
      probeEnA = 1'b1;
      probeEnB = 1'b1;
      probeEnC = 1'b1;
      repeat (3) @(posedge CLK);
      @(negedge CLK);
      rstN = 1'b1;
      @(negedge CLK);
      resetIdleTest();
      enableTest();
      wideTest();
      sendOnceTest();
      contentionTest();
      disableBadTest();
      $display("Checks finished with %0d errors after %0d cycles", errors, cycleCount);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== design/probeHub.sv ====
module probeHub (
   input  logic                             CLK,
   input  logic                             rstN,
   input  logic                             cmdEn,
   input  logic [18:0]                      cmd,
   output logic                             badCmd,
   output logic [31:0]                      upData,
   output logic                             upValid,
   input  logic                             ack,
   output logic                             hostDelay,
   input  logic [probePkg::probeWidthA-1:0] probeInA,
   input  logic                             probeEnA,
   input  logic [probePkg::probeWidthB-1:0] probeInB,
   input  logic                             probeEnB,
   input  logic [probePkg::probeWidthC-1:0] probeInC,
   input  logic                             probeEnC
);

   logic [probePkg::numProbes-1:0] probeSel;
   logic                           opEnableStb;
   logic                           opSendOnceStb;
   logic [probePkg::numProbes-1:0] dataValid;
   logic [probePkg::numProbes-1:0] delay;
   logic [probePkg::numProbes-1:0] probeAck;
   logic [31:0]                    dataUpA;
   logic [31:0]                    dataUpB;
   logic [31:0]                    dataUpC;

   cmdDecoder u_cmdDecoder (
      .CLK           (CLK),
      .rstN          (rstN),
      .cmdEn         (cmdEn),
      .cmd           (cmd),
      .probeSel      (probeSel),
      .opEnableStb   (opEnableStb),
      .opSendOnceStb (opSendOnceStb),
      .badCmd        (badCmd)
   );

   probeValue #(
      .probeId    (probePkg::probeIdA),
      .probeWidth (probePkg::probeWidthA),
      .probeWords (probePkg::probeWordsA)
   ) u_probeA (
      .CLK           (CLK),
      .rstN          (rstN),
      .probeSel      (probeSel[0]),
      .opEnableStb   (opEnableStb),
      .opSendOnceStb (opSendOnceStb),
      .probeIn       (probeInA),
      .probeEn       (probeEnA),
      .dataUp        (dataUpA),
      .dataValid     (dataValid[0]),
      .probeAck      (probeAck[0]),
      .delay         (delay[0])
   );

   probeValue #(
      .probeId    (probePkg::probeIdB),
      .probeWidth (probePkg::probeWidthB),
      .probeWords (probePkg::probeWordsB)
   ) u_probeB (
      .CLK           (CLK),
      .rstN          (rstN),
      .probeSel      (probeSel[1]),
      .opEnableStb   (opEnableStb),
      .opSendOnceStb (opSendOnceStb),
      .probeIn       (probeInB),
      .probeEn       (probeEnB),
      .dataUp        (dataUpB),
      .dataValid     (dataValid[1]),
      .probeAck      (probeAck[1]),
      .delay         (delay[1])
   );

   probeValue #(
      .probeId    (probePkg::probeIdC),
      .probeWidth (probePkg::probeWidthC),
      .probeWords (probePkg::probeWordsC)
   ) u_probeC (
      .CLK           (CLK),
      .rstN          (rstN),
      .probeSel      (probeSel[2]),
      .opEnableStb   (opEnableStb),
      .opSendOnceStb (opSendOnceStb),
      .probeIn       (probeInC),
      .probeEn       (probeEnC),
      .dataUp        (dataUpC),
      .dataValid     (dataValid[2]),
      .probeAck      (probeAck[2]),
      .delay         (delay[2])
   );

   upLinkArbiter u_upLinkArbiter (
      .CLK       (CLK),
      .rstN      (rstN),
      .dataUpA   (dataUpA),
      .dataUpB   (dataUpB),
      .dataUpC   (dataUpC),
      .dataValid (dataValid),
      .delay     (delay),
      .ack       (ack),
      .upData    (upData),
      .upValid   (upValid),
      .probeAck  (probeAck),
      .hostDelay (hostDelay)
   );

endmodule

// ==== design/upLinkArbiter.sv ====
module upLinkArbiter (
   input  logic                           CLK,
   input  logic                           rstN,
   input  logic [31:0]                    dataUpA,
   input  logic [31:0]                    dataUpB,
   input  logic [31:0]                    dataUpC,
   input  logic [probePkg::numProbes-1:0] dataValid,
   input  logic [probePkg::numProbes-1:0] delay,
   input  logic                           ack,
   output logic [31:0]                    upData,
   output logic                           upValid,
   output logic [probePkg::numProbes-1:0] probeAck,
   output logic                           hostDelay
);

   logic [probePkg::numProbes-1:0]     grant;
   logic [probePkg::numProbes-1:0]     nextGrant;
   logic [probePkg::numProbes-1:0]     liveGrant;
   logic [probePkg::grantIdxWidth-1:0] rrBase;   // First candidate in round-robin order
   logic [probePkg::grantIdxWidth-1:0] nextBase;

   assign liveGrant = grant & dataValid;
   assign upValid   = |liveGrant;
   assign probeAck  = liveGrant & {probePkg::numProbes{ack}};
   assign hostDelay = |delay;

   always_comb begin
      upData = 32'd0;
      if (grant[0]) begin
         upData = dataUpA;
      end else if (grant[1]) begin
         upData = dataUpB;
      end else if (grant[2]) begin
         upData = dataUpC;
      end
   end

   // Walk backwards so the nearest candidate after rrBase wins
   always_comb begin
      int cand;
      int after;
      nextGrant = '0;
      nextBase  = rrBase;
      for (int k = probePkg::numProbes - 1; k >= 0; k--) begin
         cand  = (int'(rrBase) + k) % probePkg::numProbes;
         after = (cand + 1) % probePkg::numProbes;
         if (dataValid[cand]) begin
            nextGrant       = '0;
            nextGrant[cand] = 1'b1;
            nextBase        = after[probePkg::grantIdxWidth-1:0];
         end
      end
   end

   // Grant locks until the owner drops dataValid
   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         grant  <= '0;
         rrBase <= '0;
      end else if (!upValid) begin
         grant <= nextGrant;
         if (|nextGrant) begin
            rrBase <= nextBase;
         end
      end
   end

   assert property (@(posedge CLK) disable iff (!rstN) ack |-> upValid)
      else $error("Host ack without a word on the uplink");

endmodule

// ==== design/probeValue.sv ====
module probeValue #(
   parameter logic [15:0] probeId    = 16'd0,
   parameter int          probeWidth = 1,
   parameter int          probeWords = 1
) (
   input  logic                  CLK,
   input  logic                  rstN,
   input  logic                  probeSel,
   input  logic                  opEnableStb,
   input  logic                  opSendOnceStb,
   input  logic [probeWidth-1:0] probeIn,
   input  logic                  probeEn,
   output logic [31:0]           dataUp,
   output logic                  dataValid,
   input  logic                  probeAck,
   output logic                  delay
);

   probePkg::upWordT upWord;

   logic [probeWidth-1:0]   probeData;
   logic                    probeChanged;
   logic                    captureChanged;
   logic [probeWords*32-1:0] captured;
   logic [probeWords*32-1:0] probeWide;

   logic       enabled;
   logic       sendOnce;
   logic       sentOne;
   logic       forced;
   logic       sending;
   logic [7:0] remaining;

   logic newSample;
   logic newData;
   logic armed;
   logic startFrame;
   logic turnOn;

   assign newSample  = probeEn && (probeIn != probeData);
   assign newData    = probeChanged != captureChanged;
   assign armed      = enabled && !sentOne;
   assign startFrame = armed && !sending && (newData || forced);
   assign turnOn     = opEnableStb || opSendOnceStb;

   assign delay     = enabled && !sendOnce && newData;
   assign dataValid = sending;
   assign dataUp    = upWord;

   // Zero padding above the probe value
   always_comb begin
      probeWide = '0;
      probeWide[probeWidth-1:0] = probeData;
   end

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         probeData    <= '0;
         probeChanged <= 1'b0;
      end else if (newSample) begin
         probeData    <= probeIn;
         probeChanged <= !probeChanged; // Toggle marks a new value
      end
   end

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         enabled        <= 1'b0;
         sendOnce       <= 1'b0;
         sentOne        <= 1'b0;
         forced         <= 1'b0;
         sending        <= 1'b0;
         remaining      <= 8'd0;
         captureChanged <= 1'b0;
      end else begin
         if (startFrame) begin
            sending   <= 1'b1;
            remaining <= 8'(probeWords);
            sentOne   <= sendOnce;
            forced    <= 1'b0;
         end else if (sending && probeAck) begin
            if (remaining != 8'd0) begin
               remaining <= remaining - 8'd1;
            end else begin
               sending        <= 1'b0;          // Last data word taken
               captureChanged <= probeChanged;
            end
         end

         // A command overrides the frame bookkeeping above
         if (probeSel) begin
            enabled        <= turnOn;
            sendOnce       <= opSendOnceStb;
            sentOne        <= 1'b0;
            forced         <= turnOn;
            captureChanged <= probeChanged;  // Forced send carries the current value
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (startFrame) begin
         upWord.header.probeId   <= probeId;
         upWord.header.reserved  <= 8'd0;
         upWord.header.wordCount <= 8'(probeWords);
         captured                <= probeWide;
      end else if (sending && probeAck && (remaining != 8'd0)) begin
         upWord.data <= captured[31:0];  // Least significant word first
         captured    <= captured >> 32;
      end
   end

   // Value must ship before the input moves again
   assert property (@(posedge CLK) disable iff (!rstN) not (delay && newSample))
      else $error("probeValue %0d overrun by a new sample", probeId);

   assert property (@(posedge CLK) disable iff (!rstN) probeAck |-> dataValid)
      else $error("probeValue %0d acknowledged while idle", probeId);

endmodule

// ==== design/cmdDecoder.sv ====
module cmdDecoder (
   input  logic                             CLK,
   input  logic                             rstN,
   input  logic                             cmdEn,
   input  logic [18:0]                      cmd,
   output logic [probePkg::numProbes-1:0]   probeSel,
   output logic                             opEnableStb,
   output logic                             opSendOnceStb,
   output logic                             badCmd
);

   logic [18:0] cmdReg;
   logic        cmdValid;
   logic [15:0] cmdProbe;
   logic [2:0]  cmdOp;
   logic        anyHit;

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         cmdValid <= 1'b0;
      end else begin
         cmdValid <= cmdEn;
      end
   end

   always_ff @(posedge CLK) begin
      if (cmdEn) begin
         cmdReg <= cmd;
      end
   end

   assign cmdProbe = cmdReg[18:3];
   assign cmdOp    = cmdReg[2:0];

   // Probe A on select bit 0
   assign probeSel[0] = cmdValid && (cmdProbe == probePkg::probeIdA);
   assign probeSel[1] = cmdValid && (cmdProbe == probePkg::probeIdB);
   assign probeSel[2] = cmdValid && (cmdProbe == probePkg::probeIdC);

   assign anyHit = |probeSel;

   assign opEnableStb   = anyHit && (cmdOp == probePkg::opEnable);
   assign opSendOnceStb = anyHit && (cmdOp == probePkg::opSendOnce);
   assign badCmd        = cmdValid && !anyHit; // Unknown probe number

   // Identifiers in the package must stay distinct
   assert property (@(posedge CLK) disable iff (!rstN) $onehot0(probeSel))
      else $error("cmdDecoder selected more than one probe");

endmodule

// ==== design/probePkg.sv ====
package probePkg;

   localparam int numProbes = 3;
   localparam int grantIdxWidth = $clog2(numProbes);

   // Any other operation code disables
   localparam logic [2:0] opEnable   = 3'd2;
   localparam logic [2:0] opSendOnce = 3'd5;

   localparam logic [15:0] probeIdA = 16'd1;
   localparam logic [15:0] probeIdB = 16'd2;
   localparam logic [15:0] probeIdC = 16'd3;

   localparam int probeWidthA = 8;
   localparam int probeWidthB = 40;
   localparam int probeWidthC = 16;

   // Whole 32-bit data words per frame
   localparam int probeWordsA = (probeWidthA + 31) / 32;
   localparam int probeWordsB = (probeWidthB + 31) / 32;
   localparam int probeWordsC = (probeWidthC + 31) / 32;

   // Header view on the first word of a frame
   typedef union packed {
      struct packed {
         logic [15:0] probeId;
         logic [7:0]  reserved;  // Always zero
         logic [7:0]  wordCount; // Data words that follow
      } header;
      logic [31:0] data;
   } upWordT;

endpackage
